// File: source/saturn_bus_pkg.sv
/* fetch bus types and constants: address and data widths,
   start address after reset and address step per read */
`default_nettype none

package saturn_bus_pkg;

  // nibble addressed program space
  localparam int WB_ADR_W = 20;
  localparam int WB_DAT_W = 4;

  // one nibble address on the fetch bus
  typedef logic [WB_ADR_W-1:0] wb_adr_t;

  // read data, always a single nibble
  typedef logic [WB_DAT_W-1:0] wb_dat_t;

  // fetch starts here and runs linearly
  localparam wb_adr_t RESET_PC = 20'h00000;

  // sequential reads, one nibble per bus cycle
  localparam wb_adr_t FETCH_STEP = 20'h00001;

endpackage

`default_nettype wire

// File: source/saturn_isa_pkg.sv
/* instruction set types and constants: nibble, alu operation, immediate
   length and data, offset lengths, first nibble and 0x opcodes */
`default_nettype none

package saturn_isa_pkg;

  localparam int NIBBLE_W = 4;

  typedef logic [NIBBLE_W-1:0] nibble_t;

  // operations handed to the execute stage
  typedef enum logic [4:0] {
    NOP      = 5'd0,
    COPY     = 5'd1,
    EXCH     = 5'd2,
    ZERO     = 5'd3,
    INC      = 5'd4,
    DEC      = 5'd5,
    JMP_REL2 = 5'd6,
    JMP_REL3 = 5'd7,
    TEST_GO  = 5'd8
  } alu_op_t;

  typedef logic [4:0] imm_len_t;

  // first collected nibble sits in bits 3:0
  typedef logic [16*NIBBLE_W-1:0] imm_data_t;

  localparam imm_len_t IMM_MAX_NIBBLES = 5'd16;

  // offset lengths of the jump blocks
  localparam imm_len_t GO_CARRY_LEN = 5'd2;
  localparam imm_len_t GOTO_LEN     = 5'd3;

  // first nibble blocks
  localparam nibble_t OPC_BLOCK_0 = 4'h0;
  localparam nibble_t OPC_LOAD_P  = 4'h2;
  localparam nibble_t OPC_LOAD_C  = 4'h3;
  localparam nibble_t OPC_GOC     = 4'h4;
  localparam nibble_t OPC_GONC    = 4'h5;
  localparam nibble_t OPC_GOTO    = 4'h6;
  localparam nibble_t OPC_GOSUB   = 4'h7;

  // second nibble of block 0x
  localparam nibble_t SUB_RTNSXM = 4'h0;
  localparam nibble_t SUB_RTN    = 4'h1;
  localparam nibble_t SUB_RTNSC  = 4'h2;
  localparam nibble_t SUB_RTNCC  = 4'h3;
  localparam nibble_t SUB_SETHEX = 4'h4;
  localparam nibble_t SUB_SETDEC = 4'h5;
  localparam nibble_t SUB_RSTK_C = 4'h6;
  localparam nibble_t SUB_C_RSTK = 4'h7;
  localparam nibble_t SUB_CLRST  = 4'h8;
  localparam nibble_t SUB_C_ST   = 4'h9;
  localparam nibble_t SUB_ST_C   = 4'hA;
  localparam nibble_t SUB_CSTEX  = 4'hB;
  localparam nibble_t SUB_P_INC  = 4'hC;
  localparam nibble_t SUB_P_DEC  = 4'hD;

endpackage

`default_nettype wire

// File: source/nibble_fetch.sv
/* wishbone classic read master for sequential program nibbles
   with a one entry prefetch buffer toward the decoder */
`default_nettype none

module nibble_fetch (
  input  wire logic                    i_clk,
  input  wire logic                    i_reset,
  output logic                         o_wb_cyc,
  output logic                         o_wb_stb,
  output saturn_bus_pkg::wb_adr_t      o_wb_adr,
  input  wire logic                    i_wb_ack,
  input  wire saturn_bus_pkg::wb_dat_t i_wb_dat,
  output logic                         o_nib_valid,
  output saturn_isa_pkg::nibble_t      o_nib_data,
  output saturn_bus_pkg::wb_adr_t      o_nib_addr,
  input  wire logic                    i_nib_take
);
  import saturn_bus_pkg::*;

  logic ack_fire;
  logic buf_free;

  assign ack_fire = o_wb_stb && i_wb_ack;

  // buffer empty now or emptied at this edge
  assign buf_free = !o_nib_valid || i_nib_take;

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      o_wb_cyc    <= 1'b0;
      o_wb_stb    <= 1'b0;
      o_wb_adr    <= RESET_PC;
      o_nib_valid <= 1'b0;
    end else begin
      if (o_wb_cyc) begin
        // cycle ends on ack, idle for at least one clock afterwards
        if (ack_fire) begin
          o_wb_cyc <= 1'b0;
          o_wb_stb <= 1'b0;
          o_wb_adr <= o_wb_adr + FETCH_STEP;
        end
      end else if (buf_free) begin
        o_wb_cyc <= 1'b1;
        o_wb_stb <= 1'b1;
      end

      if (ack_fire) begin
        o_nib_valid <= 1'b1;
      end else if (i_nib_take) begin
        o_nib_valid <= 1'b0;
      end
    end
  end

  // buffered nibble and the address it came from
  always_ff @(posedge i_clk) begin
    if (ack_fire) begin
      o_nib_data <= i_wb_dat;
      o_nib_addr <= o_wb_adr;
    end
  end

  a_stb_in_cyc: assert property (
    @(posedge i_clk) disable iff (i_reset)
    o_wb_stb |-> o_wb_cyc
  );

  // request held with the same address until the slave answers
  a_adr_hold: assert property (
    @(posedge i_clk) disable iff (i_reset)
    o_wb_stb && !i_wb_ack |=> o_wb_stb && $stable(o_wb_adr)
  );

endmodule

`default_nettype wire

// File: source/imm_collector.sv
/* immediate nibble collector: counted run of nibbles packed
   first lowest, with a flag on the nibble that completes the run */
`default_nettype none

module imm_collector (
  input  wire logic                     i_clk,
  input  wire logic                     i_reset,
  input  wire logic                     i_start,
  input  wire saturn_isa_pkg::imm_len_t i_len,
  input  wire logic                     i_push,
  input  wire saturn_isa_pkg::nibble_t  i_nibble,
  output logic                          o_last,
  output saturn_isa_pkg::imm_data_t     o_data,
  output saturn_isa_pkg::imm_len_t      o_count
);
  import saturn_isa_pkg::*;

  imm_len_t len;
  imm_len_t pos;

  assign o_count = pos;

  // completes on the push itself, not a cycle later
  assign o_last = i_push && ((pos + imm_len_t'(1)) == len);

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      len <= '0;
      pos <= '0;
    end else if (i_start) begin
      len <= i_len;
      pos <= '0;
    end else if (i_push) begin
      pos <= pos + imm_len_t'(1);
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_start) begin
      o_data <= '0;
    end else if (i_push) begin
      o_data[pos[3:0]*NIBBLE_W +: NIBBLE_W] <= i_nibble;
    end
  end

  a_pos_in_range: assert property (
    @(posedge i_clk) disable iff (i_reset)
    pos <= IMM_MAX_NIBBLES
  );

endmodule

`default_nettype wire

// File: source/opcode_sequencer.sv
/* decoder FSM: first nibble dispatch, block 0x flags, P= and LC loads,
   jump offsets, and the decoded record held until the execute stage takes it */
`default_nettype none

module opcode_sequencer (
  input  wire logic                     i_clk,
  input  wire logic                     i_reset,
  input  wire logic                     i_nib_valid,
  input  wire saturn_isa_pkg::nibble_t  i_nib_data,
  input  wire saturn_bus_pkg::wb_adr_t  i_nib_addr,
  output logic                          o_nib_take,
  output logic                          o_imm_start,
  output saturn_isa_pkg::imm_len_t      o_imm_len,
  output logic                          o_imm_push,
  input  wire logic                     i_imm_last,
  input  wire logic                     i_ins_ready,
  output logic                          o_ins_valid,
  output saturn_bus_pkg::wb_adr_t       o_ins_addr,
  output saturn_isa_pkg::alu_op_t       o_alu_op,
  output logic                          o_ins_alu_op,
  output saturn_isa_pkg::nibble_t       o_imm_value,
  output logic                          o_ins_rtn,
  output logic                          o_push,
  output logic                          o_pop,
  output logic                          o_set_xm,
  output logic                          o_set_carry,
  output logic                          o_carry_val,
  output logic                          o_test_carry,
  output logic                          o_ins_set_mode,
  output logic                          o_mode_dec,
  output logic                          o_dec_error
);
  import saturn_isa_pkg::*;

  typedef enum logic [2:0] {
    FIRST,
    BLOCK_0,
    LOAD_P,
    LOAD_C_COUNT,
    COLLECT,
    HOLD
  } state_t;

  state_t state;
  logic   nib_fire;

  // no nibble taken while a record waits
  assign o_nib_take = (state != HOLD);
  assign nib_fire   = i_nib_valid && o_nib_take;

  // collector restarts on every first nibble, so non-immediate records see length 0
  assign o_imm_start = nib_fire && (state == FIRST || state == LOAD_C_COUNT);
  assign o_imm_push  = nib_fire && (state == COLLECT);

  always_comb begin
    o_imm_len = '0;
    if (state == LOAD_C_COUNT) begin
      o_imm_len = imm_len_t'(i_nib_data) + imm_len_t'(1);
    end else if (i_nib_data == OPC_GOC || i_nib_data == OPC_GONC) begin
      o_imm_len = GO_CARRY_LEN;
    end else if (i_nib_data == OPC_GOTO || i_nib_data == OPC_GOSUB) begin
      o_imm_len = GOTO_LEN;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      state          <= FIRST;
      o_ins_valid    <= 1'b0;
      o_alu_op       <= NOP;
      o_ins_alu_op   <= 1'b0;
      o_ins_rtn      <= 1'b0;
      o_push         <= 1'b0;
      o_pop          <= 1'b0;
      o_set_xm       <= 1'b0;
      o_set_carry    <= 1'b0;
      o_carry_val    <= 1'b0;
      o_test_carry   <= 1'b0;
      o_ins_set_mode <= 1'b0;
      o_mode_dec     <= 1'b0;
      o_dec_error    <= 1'b0;
    end else begin
      case (state)
        FIRST: begin
          if (nib_fire) begin
            o_ins_addr     <= i_nib_addr;
            o_imm_value    <= '0;
            o_alu_op       <= NOP;
            o_ins_alu_op   <= 1'b0;
            o_ins_rtn      <= 1'b0;
            o_push         <= 1'b0;
            o_pop          <= 1'b0;
            o_set_xm       <= 1'b0;
            o_set_carry    <= 1'b0;
            o_carry_val    <= 1'b0;
            o_test_carry   <= 1'b0;
            o_ins_set_mode <= 1'b0;
            o_mode_dec     <= 1'b0;
            o_dec_error    <= 1'b0;
            case (i_nib_data)
              OPC_BLOCK_0: state <= BLOCK_0;
              OPC_LOAD_P:  state <= LOAD_P;
              OPC_LOAD_C:  state <= LOAD_C_COUNT;
              OPC_GOC, OPC_GONC: begin
                o_alu_op     <= JMP_REL2;
                o_test_carry <= 1'b1;
                o_carry_val  <= (i_nib_data == OPC_GOC);
                state        <= COLLECT;
              end
              OPC_GOTO, OPC_GOSUB: begin
                o_alu_op <= JMP_REL3;
                o_push   <= (i_nib_data == OPC_GOSUB);
                state    <= COLLECT;
              end
              default: begin
                // unsupported block, resync on the next nibble
                o_dec_error <= 1'b1;
                o_ins_valid <= 1'b1;
                state       <= HOLD;
              end
            endcase
          end
        end

        BLOCK_0: begin
          if (nib_fire) begin
            case (i_nib_data)
              SUB_RTNSXM, SUB_RTN, SUB_RTNSC, SUB_RTNCC: begin
                o_ins_rtn   <= 1'b1;
                o_pop       <= 1'b1;
                o_set_xm    <= (i_nib_data == SUB_RTNSXM);
                o_set_carry <= (i_nib_data == SUB_RTNSC || i_nib_data == SUB_RTNCC);
                o_carry_val <= (i_nib_data == SUB_RTNSC);
              end
              SUB_SETHEX, SUB_SETDEC: begin
                o_ins_set_mode <= 1'b1;
                o_mode_dec     <= (i_nib_data == SUB_SETDEC);
              end
              SUB_RSTK_C, SUB_C_RSTK: begin
                o_ins_alu_op <= 1'b1;
                o_alu_op     <= COPY;
                o_push       <= (i_nib_data == SUB_RSTK_C);
                o_pop        <= (i_nib_data == SUB_C_RSTK);
              end
              SUB_CLRST: begin
                o_ins_alu_op <= 1'b1;
                o_alu_op     <= ZERO;
              end
              SUB_C_ST, SUB_ST_C: begin
                o_ins_alu_op <= 1'b1;
                o_alu_op     <= COPY;
              end
              SUB_CSTEX: begin
                o_ins_alu_op <= 1'b1;
                o_alu_op     <= EXCH;
              end
              SUB_P_INC, SUB_P_DEC: begin
                o_ins_alu_op <= 1'b1;
                o_alu_op     <= (i_nib_data == SUB_P_DEC) ? DEC : INC;
              end
              // 0E and 0F
              default: o_dec_error <= 1'b1;
            endcase
            o_ins_valid <= 1'b1;
            state       <= HOLD;
          end
        end

        LOAD_P: begin
          if (nib_fire) begin
            o_ins_alu_op <= 1'b1;
            o_alu_op     <= COPY;
            o_imm_value  <= i_nib_data;
            o_ins_valid  <= 1'b1;
            state        <= HOLD;
          end
        end

        LOAD_C_COUNT: begin
          if (nib_fire) begin
            o_ins_alu_op <= 1'b1;
            o_alu_op     <= COPY;
            state        <= COLLECT;
          end
        end

        COLLECT: begin
          if (nib_fire) begin
            // last nibble seen stays visible in the record
            o_imm_value <= i_nib_data;
            if (i_imm_last) begin
              o_ins_valid <= 1'b1;
              state       <= HOLD;
            end
          end
        end

        HOLD: begin
          if (i_ins_ready) begin
            o_ins_valid <= 1'b0;
            state       <= FIRST;
          end
        end

        default: state <= FIRST;
      endcase
    end
  end

  // execute stage stall freezes the whole record
  a_record_hold: assert property (
    @(posedge i_clk) disable iff (i_reset)
    o_ins_valid && !i_ins_ready |=> o_ins_valid && $stable(o_ins_addr)
      && $stable(o_alu_op) && $stable(o_ins_alu_op) && $stable(o_imm_value)
      && $stable(o_ins_rtn) && $stable(o_push) && $stable(o_pop)
      && $stable(o_set_xm) && $stable(o_set_carry) && $stable(o_carry_val)
      && $stable(o_test_carry) && $stable(o_ins_set_mode) && $stable(o_mode_dec)
      && $stable(o_dec_error)
  );

endmodule

`default_nettype wire

// File: source/saturn_decoder_top.sv
/* decoder top level: nibble fetch on the wishbone side,
   opcode sequencer and immediate collector toward execute */
`default_nettype none

module saturn_decoder_top (
  input  wire logic                    i_clk,
  input  wire logic                    i_reset,
  output logic                         o_wb_cyc,
  output logic                         o_wb_stb,
  output saturn_bus_pkg::wb_adr_t      o_wb_adr,
  input  wire logic                    i_wb_ack,
  input  wire saturn_bus_pkg::wb_dat_t i_wb_dat,
  input  wire logic                    i_ins_ready,
  output logic                         o_ins_valid,
  output saturn_bus_pkg::wb_adr_t      o_ins_addr,
  output saturn_isa_pkg::alu_op_t      o_alu_op,
  output logic                         o_ins_alu_op,
  output saturn_isa_pkg::nibble_t      o_imm_value,
  output saturn_isa_pkg::imm_data_t    o_imm_data,
  output saturn_isa_pkg::imm_len_t     o_imm_len,
  output logic                         o_ins_rtn,
  output logic                         o_push,
  output logic                         o_pop,
  output logic                         o_set_xm,
  output logic                         o_set_carry,
  output logic                         o_carry_val,
  output logic                         o_test_carry,
  output logic                         o_ins_set_mode,
  output logic                         o_mode_dec,
  output logic                         o_dec_error
);
  import saturn_bus_pkg::*;
  import saturn_isa_pkg::*;

  // nibble stream
  logic     nib_valid;
  nibble_t  nib_data;
  wb_adr_t  nib_addr;
  logic     nib_take;

  // immediate path
  logic     imm_start;
  imm_len_t imm_len;
  logic     imm_push;
  logic     imm_last;

  nibble_fetch u_fetch (
    .i_clk      (i_clk),
    .i_reset    (i_reset),
    .o_wb_cyc   (o_wb_cyc),
    .o_wb_stb   (o_wb_stb),
    .o_wb_adr   (o_wb_adr),
    .i_wb_ack   (i_wb_ack),
    .i_wb_dat   (i_wb_dat),
    .o_nib_valid(nib_valid),
    .o_nib_data (nib_data),
    .o_nib_addr (nib_addr),
    .i_nib_take (nib_take)
  );

  opcode_sequencer u_seq (
    .i_clk         (i_clk),
    .i_reset       (i_reset),
    .i_nib_valid   (nib_valid),
    .i_nib_data    (nib_data),
    .i_nib_addr    (nib_addr),
    .o_nib_take    (nib_take),
    .o_imm_start   (imm_start),
    .o_imm_len     (imm_len),
    .o_imm_push    (imm_push),
    .i_imm_last    (imm_last),
    .i_ins_ready   (i_ins_ready),
    .o_ins_valid   (o_ins_valid),
    .o_ins_addr    (o_ins_addr),
    .o_alu_op      (o_alu_op),
    .o_ins_alu_op  (o_ins_alu_op),
    .o_imm_value   (o_imm_value),
    .o_ins_rtn     (o_ins_rtn),
    .o_push        (o_push),
    .o_pop         (o_pop),
    .o_set_xm      (o_set_xm),
    .o_set_carry   (o_set_carry),
    .o_carry_val   (o_carry_val),
    .o_test_carry  (o_test_carry),
    .o_ins_set_mode(o_ins_set_mode),
    .o_mode_dec    (o_mode_dec),
    .o_dec_error   (o_dec_error)
  );

  // pushed nibble comes straight from the prefetch buffer
  imm_collector u_imm (
    .i_clk   (i_clk),
    .i_reset (i_reset),
    .i_start (imm_start),
    .i_len   (imm_len),
    .i_push  (imm_push),
    .i_nibble(nib_data),
    .o_last  (imm_last),
    .o_data  (o_imm_data),
    .o_count (o_imm_len)
  );

endmodule

`default_nettype wire

// File: testbench/tb_program_mem.sv
/* wishbone classic read slave holding the test program,
   acknowledges each read after 0 to 2 random wait cycles */
`default_nettype none

module tb_program_mem (
  input  wire logic                    i_clk,
  input  wire logic                    i_cyc,
  input  wire logic                    i_stb,
  input  wire saturn_bus_pkg::wb_adr_t i_adr,
  output logic                         o_ack,
  output saturn_bus_pkg::wb_dat_t      o_dat
);
  timeunit 1ns;
  timeprecision 1ns;
  import saturn_bus_pkg::*;

  localparam int PROG_LEN  = 61;
  localparam int MEM_DEPTH = 64;

  // fetch order, first nibble in the top digit
  localparam logic [4*PROG_LEN-1:0] PROGRAM =
    244'h0001020304050607_08090A0B0C0D0E0F_25_32ABC_412_534_6567_789A_18ABCDEF;

  wb_dat_t mem [MEM_DEPTH];
  int      seed = 3;
  int      wait_left;
  logic    pending;

  // unused cells mix every nibble of the address
  function automatic wb_dat_t fill_nibble(input wb_adr_t adr);
    return adr[3:0] ^ adr[7:4] ^ adr[11:8] ^ adr[15:12] ^ adr[19:16];
  endfunction

  function automatic wb_dat_t read_nibble(input wb_adr_t adr);
    if (adr < MEM_DEPTH) begin
      return mem[adr[5:0]];
    end
    return fill_nibble(adr);
  endfunction

  initial begin
    o_ack     = 1'b0;
    o_dat     = '0;
    pending   = 1'b0;
    wait_left = 0;
    for (int i = 0; i < MEM_DEPTH; i++) begin
      mem[i] = fill_nibble(wb_adr_t'(i));
    end
    for (int i = 0; i < PROG_LEN; i++) begin
      mem[i] = PROGRAM[4*(PROG_LEN-1-i) +: 4];
    end
  end

  // new request picks its wait count, ack drops after the ack edge
  always @(posedge i_clk) begin
    #1;
    o_ack = 1'b0;
    if (i_cyc && i_stb) begin
      if (!pending) begin
        pending   = 1'b1;
        wait_left = $unsigned($random(seed)) % 3;
      end
      if (wait_left == 0) begin
        o_ack   = 1'b1;
        o_dat   = read_nibble(i_adr);
        pending = 1'b0;
      end else begin
        wait_left--;
      end
    end
  end

endmodule

`default_nettype wire

// File: testbench/tb_saturn_decoder.sv
/* testbench for the saturn decoder: clock, reset, random ready,
   expected record table and the checking assertions */
`default_nettype none

module tb_saturn_decoder;
  timeunit 1ns;
  timeprecision 1ns;
  import saturn_bus_pkg::*;
  import saturn_isa_pkg::*;

  // about 60 nibbles at up to 4 cycles each, plus ready stalls
  localparam int TIMEOUT_CYCLES = 2000;
  localparam int RESET_CYCLES   = 8;

  logic      clk = 1'b0;
  logic      reset = 1'b1;
  logic      ins_ready = 1'b0;
  logic      wb_cyc;
  logic      wb_stb;
  wb_adr_t   wb_adr;
  logic      wb_ack;
  wb_dat_t   wb_dat;
  logic      ins_valid;
  wb_adr_t   ins_addr;
  alu_op_t   alu_op;
  logic      ins_alu_op;
  nibble_t   imm_value;
  imm_data_t imm_data;
  imm_len_t  imm_len;
  logic      ins_rtn;
  logic      push;
  logic      pop;
  logic      set_xm;
  logic      set_carry;
  logic      carry_val;
  logic      test_carry;
  logic      ins_set_mode;
  logic      mode_dec;
  logic      dec_error;

  logic [10:0]  flags;
  logic [108:0] record;
  wb_adr_t      next_ack_adr;

  // expected records, one entry per instruction
  wb_adr_t      exp_addr[$];
  alu_op_t      exp_op[$];
  logic [10:0]  exp_flags[$];
  nibble_t      exp_value[$];
  imm_len_t     exp_len[$];
  imm_data_t    exp_data[$];
  wb_adr_t      next_ins_addr = '0;
  int           rec_idx = 0;
  int           cycles = 0;
  int           seed = 3;
  int           rnd;

  string flag_names [11] = '{
    "o_ins_alu_op", "o_ins_rtn", "o_push", "o_pop", "o_set_xm", "o_set_carry",
    "o_carry_val", "o_test_carry", "o_ins_set_mode", "o_mode_dec", "o_dec_error"
  };

  assign flags = {ins_alu_op, ins_rtn, push, pop, set_xm, set_carry, carry_val,
                  test_carry, ins_set_mode, mode_dec, dec_error};
  assign record = {ins_addr, alu_op, imm_value, imm_data, imm_len, flags};

  always #50 clk = ~clk;

  saturn_decoder_top u_dut (
    .i_clk         (clk),
    .i_reset       (reset),
    .o_wb_cyc      (wb_cyc),
    .o_wb_stb      (wb_stb),
    .o_wb_adr      (wb_adr),
    .i_wb_ack      (wb_ack),
    .i_wb_dat      (wb_dat),
    .i_ins_ready   (ins_ready),
    .o_ins_valid   (ins_valid),
    .o_ins_addr    (ins_addr),
    .o_alu_op      (alu_op),
    .o_ins_alu_op  (ins_alu_op),
    .o_imm_value   (imm_value),
    .o_imm_data    (imm_data),
    .o_imm_len     (imm_len),
    .o_ins_rtn     (ins_rtn),
    .o_push        (push),
    .o_pop         (pop),
    .o_set_xm      (set_xm),
    .o_set_carry   (set_carry),
    .o_carry_val   (carry_val),
    .o_test_carry  (test_carry),
    .o_ins_set_mode(ins_set_mode),
    .o_mode_dec    (mode_dec),
    .o_dec_error   (dec_error)
  );

  tb_program_mem u_mem (
    .i_clk(clk),
    .i_cyc(wb_cyc),
    .i_stb(wb_stb),
    .i_adr(wb_adr),
    .o_ack(wb_ack),
    .o_dat(wb_dat)
  );

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("** FAIL **");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_field(input string name, input logic [63:0] got,
                             input logic [63:0] want);
    assert (got === want)
      else fail_run($sformatf("MISMATCH %s: got %0h expected %0h at record %0d",
                              name, got, want, rec_idx));
  endtask

  // record address follows from the lengths of the earlier instructions
  task automatic add_rec(input int len, input alu_op_t op, input logic [10:0] fl,
                         input nibble_t value, input imm_len_t ilen, input imm_data_t data);
    exp_addr.push_back(next_ins_addr);
    exp_op.push_back(op);
    exp_flags.push_back(fl);
    exp_value.push_back(value);
    exp_len.push_back(ilen);
    exp_data.push_back(data);
    next_ins_addr += wb_adr_t'(len);
  endtask

  // flags: alu | rtn push pop xm | set_carry carry_val test_carry | mode dec | error
  task automatic build_table();
    add_rec(2, NOP,      11'b0_1011_000_00_0, 4'h0, 5'd0, 64'h0);
    add_rec(2, NOP,      11'b0_1010_000_00_0, 4'h0, 5'd0, 64'h0);
    add_rec(2, NOP,      11'b0_1010_110_00_0, 4'h0, 5'd0, 64'h0);
    add_rec(2, NOP,      11'b0_1010_100_00_0, 4'h0, 5'd0, 64'h0);
    add_rec(2, NOP,      11'b0_0000_000_10_0, 4'h0, 5'd0, 64'h0);
    add_rec(2, NOP,      11'b0_0000_000_11_0, 4'h0, 5'd0, 64'h0);
    add_rec(2, COPY,     11'b1_0100_000_00_0, 4'h0, 5'd0, 64'h0);
    add_rec(2, COPY,     11'b1_0010_000_00_0, 4'h0, 5'd0, 64'h0);
    add_rec(2, ZERO,     11'b1_0000_000_00_0, 4'h0, 5'd0, 64'h0);
    add_rec(2, COPY,     11'b1_0000_000_00_0, 4'h0, 5'd0, 64'h0);
    add_rec(2, COPY,     11'b1_0000_000_00_0, 4'h0, 5'd0, 64'h0);
    add_rec(2, EXCH,     11'b1_0000_000_00_0, 4'h0, 5'd0, 64'h0);
    add_rec(2, INC,      11'b1_0000_000_00_0, 4'h0, 5'd0, 64'h0);
    add_rec(2, DEC,      11'b1_0000_000_00_0, 4'h0, 5'd0, 64'h0);
    add_rec(2, NOP,      11'b0_0000_000_00_1, 4'h0, 5'd0, 64'h0);
    add_rec(2, NOP,      11'b0_0000_000_00_1, 4'h0, 5'd0, 64'h0);
    add_rec(2, COPY,     11'b1_0000_000_00_0, 4'h5, 5'd0, 64'h0);
    add_rec(5, COPY,     11'b1_0000_000_00_0, 4'hC, 5'd3, 64'hCBA);
    add_rec(3, JMP_REL2, 11'b0_0000_011_00_0, 4'h2, 5'd2, 64'h21);
    add_rec(3, JMP_REL2, 11'b0_0000_001_00_0, 4'h4, 5'd2, 64'h43);
    add_rec(4, JMP_REL3, 11'b0_0000_000_00_0, 4'h7, 5'd3, 64'h765);
    add_rec(4, JMP_REL3, 11'b0_0100_000_00_0, 4'hA, 5'd3, 64'hA98);
    // single nibble errors 1, 8 and A to F
    repeat (8) add_rec(1, NOP, 11'b0_0000_000_00_1, 4'h0, 5'd0, 64'h0);
  endtask

  // mostly ready, with occasional stalls
  always @(posedge clk) begin
    #1;
    rnd = $random(seed);
    ins_ready = rnd[0] | rnd[1];
  end

  always @(posedge clk) begin
    if (reset) begin
      next_ack_adr <= RESET_PC;
    end else if (wb_stb && wb_ack) begin
      next_ack_adr <= next_ack_adr + 20'd1;
    end
  end

  a_stb_cyc: assert property (@(posedge clk) disable iff (reset) wb_stb |-> wb_cyc)
    else fail_run("wishbone stb was high without cyc");

  a_adr_stable: assert property (@(posedge clk) disable iff (reset)
    wb_stb && !wb_ack |=> wb_stb && $stable(wb_adr))
    else fail_run("wishbone request dropped or address changed before ack");

  a_adr_seq: assert property (@(posedge clk) disable iff (reset)
    wb_stb && wb_ack |-> wb_adr == next_ack_adr)
    else fail_run($sformatf("MISMATCH o_wb_adr: got %0h expected %0h",
                            $sampled(wb_adr), $sampled(next_ack_adr)));

  a_record_hold: assert property (@(posedge clk) disable iff (reset)
    ins_valid && !ins_ready |=> ins_valid && $stable(record))
    else fail_run("record output changed while the execute stage stalled");

  // compared half a cycle before the transfer edge
  always @(negedge clk) begin
    if (!reset && ins_valid && ins_ready && rec_idx < exp_addr.size()) begin
      check_field("o_ins_addr", ins_addr, exp_addr[rec_idx]);
      check_field("o_alu_op", alu_op, exp_op[rec_idx]);
      check_field("o_imm_value", imm_value, exp_value[rec_idx]);
      check_field("o_imm_len", imm_len, exp_len[rec_idx]);
      check_field("o_imm_data", imm_data, exp_data[rec_idx]);
      for (int i = 0; i < 11; i++) begin
        check_field(flag_names[i], flags[10-i], exp_flags[rec_idx][10-i]);
      end
      rec_idx++;
    end
  end

  initial begin
    build_table();
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    reset = 1'b0;
    while (rec_idx < exp_addr.size() && cycles < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    if (rec_idx == exp_addr.size()) begin
      $display("** PASS **");
      $finish;
    end else begin
      fail_run($sformatf("timeout after %0d cycles with %0d of %0d records seen",
                         cycles, rec_idx, exp_addr.size()));
    end
  end

endmodule

`default_nettype wire

// File: filelist.f
source/saturn_bus_pkg.sv
source/saturn_isa_pkg.sv
source/nibble_fetch.sv
source/imm_collector.sv
source/opcode_sequencer.sv
source/saturn_decoder_top.sv
testbench/tb_program_mem.sv
testbench/tb_saturn_decoder.sv
